//--- common/tlb_walk_pkg.sv
package tlb_walk_pkg;

	// arbiter opcode for a full line read.
	localparam logic [2:0] ltc_opc_read = 3'b001;

	// cycles a line read may stay outstanding before it faults.
	localparam int unsigned walk_timeout_cycles = 64;

	// must be wide enough to hold walk_timeout_cycles itself.
	localparam int unsigned walk_timer_width = 7;

	// walk FSM states.
	typedef enum logic [1:0] {
		idle      = 2'd0,
		wait_dir  = 2'd1,
		wait_leaf = 2'd2
	} walk_state_e;

	// level-1 directory entry.
	typedef struct packed {
		logic [19:0] frame;  // frame of the level-2 table.
		logic [7:0]  unused;
		logic        g;      // global.
		logic        k;      // kernel only.
		logic        w;      // writable.
		logic        p;      // present.
	} pt_dir_t;

	// level-2 leaf entry, also the layout of the walk response.
	typedef struct packed {
		logic [19:0] frame;  // physical frame.
		logic [6:0]  rsvd;
		logic        timeout; // only ever set in a response.
		logic        g;
		logic        k;
		logic        w;
		logic        p;
	} pt_leaf_t;

	// one table word, read as directory or as leaf depending on the level.
	typedef union packed {
		pt_dir_t  dir;
		pt_leaf_t leaf;
	} pt_entry_u;

endpackage

//--- hw/tlb_walk/walk_fsm.sv
`timescale 1ns/1ns

module walk_fsm (
	input  logic                  clkrst_mem_clk,
	input  logic                  clkrst_mem_rst_n,
	input  logic                  request,
	input  logic [19:0]           reqaddr,
	input  logic [19:0]           ptbr,
	input  tlb_walk_pkg::pt_entry_u entry,
	input  logic                  rvalid,
	input  logic                  timeout,
	output logic                  want_read,
	output logic [29:0]           want_addr,
	output logic                  stall,
	output logic [31:0]           response
);
	import tlb_walk_pkg::*;

	walk_state_e state;
	walk_state_e state_next;
	logic        done;
	logic        finish;
	logic        dir_load;
	logic [2:0]  dir_gkw;    // g, k, w of the directory entry.
	pt_entry_u   resp_next;
	pt_entry_u   response_q;

	// done is high for exactly the response cycle.
	assign stall    = request && !done;
	assign response = response_q;

	// level-1 address while idle, level-2 address from the fetched directory word otherwise.
	assign want_addr = (state == idle) ? {ptbr, reqaddr[19:10]}
	                                   : {entry.dir.frame, reqaddr[9:0]};

	always_comb begin
		state_next = state;
		want_read  = 1'b0;
		finish     = 1'b0;
		dir_load   = 1'b0;
		resp_next  = '0;
		case (state)
		idle: begin
			if (request && !done) begin  // done keeps a held request from restarting.
				want_read  = 1'b1;
				state_next = wait_dir;
			end
		end
		wait_dir: begin
			if (timeout) begin
				finish                 = 1'b1;
				resp_next.leaf.timeout = 1'b1;
				state_next             = idle;
			end else if (rvalid) begin
				if (entry.dir.p) begin
					want_read  = 1'b1;  // straight on to the leaf.
					dir_load   = 1'b1;
					state_next = wait_leaf;
				end else begin
					finish     = 1'b1;  // all-zero response.
					state_next = idle;
				end
			end
		end
		wait_leaf: begin
			if (timeout) begin
				finish                 = 1'b1;
				resp_next.leaf.timeout = 1'b1;
				state_next             = idle;
			end else if (rvalid) begin
				finish               = 1'b1;
				resp_next.leaf.frame = entry.leaf.frame;
				resp_next.leaf.g     = entry.leaf.g | dir_gkw[2];
				resp_next.leaf.k     = entry.leaf.k | dir_gkw[1];
				resp_next.leaf.w     = entry.leaf.w & dir_gkw[0];
				resp_next.leaf.p     = entry.leaf.p;
				state_next           = idle;
			end
		end
		default: state_next = idle;
		endcase
	end

	always_ff @(posedge clkrst_mem_clk or negedge clkrst_mem_rst_n) begin
		if (!clkrst_mem_rst_n) begin
			state <= idle;
			done  <= 1'b0;
		end else begin
			state <= state_next;
			done  <= finish;
		end
	end

	always_ff @(posedge clkrst_mem_clk) begin
		if (dir_load)
			dir_gkw <= {entry.dir.g, entry.dir.k, entry.dir.w};
		if (finish)
			response_q <= resp_next;
	end

	// the arbiter only answers reads this FSM asked for.
	a_no_rvalid_idle: assert property (@(posedge clkrst_mem_clk) disable iff (!clkrst_mem_rst_n)
		(state == idle) |-> !rvalid)
		else $error("line returned while the walker is idle.");

	a_no_timeout_idle: assert property (@(posedge clkrst_mem_clk) disable iff (!clkrst_mem_rst_n)
		(state == idle) |-> !timeout)
		else $error("watchdog fired while the walker is idle.");

	a_state_legal: assert property (@(posedge clkrst_mem_clk) disable iff (!clkrst_mem_rst_n)
		state inside {idle, wait_dir, wait_leaf})
		else $error("walk state outside the legal set.");

endmodule

//--- hw/tlb_walk/arb_read_issue.sv
`timescale 1ns/1ns

module arb_read_issue (
	input  logic         clkrst_mem_clk,
	input  logic         clkrst_mem_rst_n,
	input  logic         want_read,
	input  logic [29:0]  want_addr,
	input  logic         arb_stall,
	output logic         arb_valid,
	output logic [2:0]   arb_opcode,
	output logic [31:5]  arb_addr,
	output logic [255:0] arb_wdata,
	output logic [31:0]  arb_wbe,
	output logic         accepted
);
	import tlb_walk_pkg::*;

	logic        pending;       // read that arrived under stall.
	logic [26:0] pending_addr;

	// read-only port.
	assign arb_opcode = arb_valid ? ltc_opc_read : 3'b000;
	assign arb_wdata  = '0;
	assign arb_wbe    = '0;

	assign accepted = arb_valid && !arb_stall;

	always_ff @(posedge clkrst_mem_clk or negedge clkrst_mem_rst_n) begin
		if (!clkrst_mem_rst_n) begin
			arb_valid <= 1'b0;
			pending   <= 1'b0;
		end else if (arb_stall) begin
			// arb_valid holds while stalled.
			if (want_read)
				pending <= 1'b1;
		end else begin
			arb_valid <= want_read || pending;
			pending   <= 1'b0;
		end
	end

	// line address is the word address without its three word-index bits.
	always_ff @(posedge clkrst_mem_clk) begin
		if (arb_stall) begin
			if (want_read)
				pending_addr <= want_addr[29:3];
		end else if (pending) begin
			arb_addr <= pending_addr;
		end else if (want_read) begin
			arb_addr <= want_addr[29:3];
		end
	end

	// one walk keeps at most one read in flight.
	a_single_read: assert property (@(posedge clkrst_mem_clk) disable iff (!clkrst_mem_rst_n)
		want_read |-> !pending && !arb_valid)
		else $error("new read requested while one is still queued.");

	a_hold_under_stall: assert property (@(posedge clkrst_mem_clk) disable iff (!clkrst_mem_rst_n)
		arb_valid && arb_stall |=> arb_valid && $stable(arb_addr))
		else $error("read request changed while the arbiter stalled.");

endmodule

//--- hw/tlb_walk/line_word_select.sv
`timescale 1ns/1ns

module line_word_select (
	input  logic                    clkrst_mem_clk,
	input  logic                    clkrst_mem_rst_n,
	input  logic                    want_read,
	input  logic [2:0]              word_index,
	input  logic [255:0]            arb_rdata,
	output tlb_walk_pkg::pt_entry_u entry
);

	logic [2:0]       word_sel;  // word of the read in flight.
	logic [7:0][31:0] words;

	always_ff @(posedge clkrst_mem_clk or negedge clkrst_mem_rst_n) begin
		if (!clkrst_mem_rst_n)
			word_sel <= 3'd0;
		else if (want_read)
			word_sel <= word_index;
	end

	// word 0 sits in the low 32 bits of the line.
	assign words = arb_rdata;
	assign entry = words[word_sel];

endmodule

//--- hw/tlb_walk/walk_timer.sv
`timescale 1ns/1ns

module walk_timer (
	input  logic clkrst_mem_clk,
	input  logic clkrst_mem_rst_n,
	input  logic accepted,
	input  logic rvalid,
	output logic timeout
);
	import tlb_walk_pkg::*;

	logic                        running;
	logic [walk_timer_width-1:0] count;   // cycles since acceptance.

	assign timeout = running && (count == walk_timer_width'(walk_timeout_cycles));

	always_ff @(posedge clkrst_mem_clk or negedge clkrst_mem_rst_n) begin
		if (!clkrst_mem_rst_n) begin
			running <= 1'b0;
			count   <= '0;
		end else if (accepted) begin
			running <= 1'b1;
			count   <= '0;
		end else if (running) begin
			if (rvalid || timeout)
				running <= 1'b0;  // line back or expired.
			else
				count <= count + 1'b1;
		end
	end

	// a line must never come back after its read has timed out.
	a_rvalid_running: assert property (@(posedge clkrst_mem_clk) disable iff (!clkrst_mem_rst_n)
		rvalid |-> running)
		else $error("line returned with no read being timed.");

endmodule

//--- hw/tlb_walk/tlb_walk_top.sv
`timescale 1ns/1ns

module tlb_walk_top (
	input  logic         clkrst_mem_clk,
	input  logic         clkrst_mem_rst_n,
	input  logic         request,
	input  logic [19:0]  reqaddr,
	input  logic [19:0]  ptbr,
	output logic         stall,
	output logic [31:0]  response,
	input  logic         arb_stall,
	output logic         arb_valid,
	output logic [2:0]   arb_opcode,
	output logic [31:5]  arb_addr,
	output logic [255:0] arb_wdata,
	output logic [31:0]  arb_wbe,
	input  logic         arb_rvalid,
	input  logic [255:0] arb_rdata
);
	import tlb_walk_pkg::*;

	logic        want_read;
	logic [29:0] want_addr;  // word address.
	logic        accepted;
	logic        timeout;
	pt_entry_u   entry;

	walk_fsm walk_fsm_i (
		.clkrst_mem_clk   (clkrst_mem_clk),
		.clkrst_mem_rst_n (clkrst_mem_rst_n),
		.request          (request),
		.reqaddr          (reqaddr),
		.ptbr             (ptbr),
		.entry            (entry),
		.rvalid           (arb_rvalid),
		.timeout          (timeout),
		.want_read        (want_read),
		.want_addr        (want_addr),
		.stall            (stall),
		.response         (response)
	);

	arb_read_issue arb_read_issue_i (
		.clkrst_mem_clk   (clkrst_mem_clk),
		.clkrst_mem_rst_n (clkrst_mem_rst_n),
		.want_read        (want_read),
		.want_addr        (want_addr),
		.arb_stall        (arb_stall),
		.arb_valid        (arb_valid),
		.arb_opcode       (arb_opcode),
		.arb_addr         (arb_addr),
		.arb_wdata        (arb_wdata),
		.arb_wbe          (arb_wbe),
		.accepted         (accepted)
	);

	line_word_select line_word_select_i (
		.clkrst_mem_clk   (clkrst_mem_clk),
		.clkrst_mem_rst_n (clkrst_mem_rst_n),
		.want_read        (want_read),
		.word_index       (want_addr[2:0]),
		.arb_rdata        (arb_rdata),
		.entry            (entry)
	);

	walk_timer walk_timer_i (
		.clkrst_mem_clk   (clkrst_mem_clk),
		.clkrst_mem_rst_n (clkrst_mem_rst_n),
		.accepted         (accepted),
		.rvalid           (arb_rvalid),
		.timeout          (timeout)
	);

endmodule

//--- dv/tlb_walk_tb.sv
`timescale 1ns/1ns

module tlb_walk_tb;
	import tlb_walk_pkg::*;

	localparam int max_tests  = 16;
	localparam int resp_limit = 400;  // watchdog plus stall and latency slack.

	logic         clkrst_mem_clk;
	logic         clkrst_mem_rst_n;
	logic         request;
	logic [19:0]  reqaddr;
	logic [19:0]  ptbr;
	logic         stall;
	logic [31:0]  response;
	logic         arb_stall = 1'b0;
	logic         arb_valid;
	logic [2:0]   arb_opcode;
	logic [31:5]  arb_addr;
	logic [255:0] arb_wdata;
	logic [31:0]  arb_wbe;
	logic         arb_rvalid = 1'b0;
	logic [255:0] arb_rdata = '0;

	logic [31:0] mem [logic [29:0]];  // sparse memory image.
	bit          dead_line [logic [26:0]];

	int          num_tests = 0;
	int          t_num [max_tests];
	logic [19:0] t_ptbr [max_tests];
	logic [19:0] t_reqaddr [max_tests];
	logic [31:0] t_expect [max_tests];
	int          t_stall [max_tests];

	int          errors = 0;
	int          resp_seen = 0;
	int          read_total = 0;
	int          read_base = 0;
	logic [26:0] exp_line [2];       // level-1 and level-2 line of the current walk.
	logic        stall_en = 1'b0;
	logic [31:0] rand_state = 32'he106fb9d;
	logic        busy = 1'b0;
	logic [2:0]  latency = 3'd0;
	logic [26:0] busy_line = '0;
	logic        held = 1'b0;
	logic [26:0] held_addr = '0;

	tlb_walk_top dut_i (.*);

	initial clkrst_mem_clk = 1'b0;
	always #2 clkrst_mem_clk = ~clkrst_mem_clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// unmapped words are not present and unique per address.
	function automatic logic [31:0] mem_word(input logic [29:0] addr);
		if (mem.exists(addr))
			return mem[addr];
		return {addr, 2'b10};
	endfunction

	function automatic logic [255:0] build_line(input logic [26:0] line);
		logic [255:0] data;
		int           i;
		data = '0;
		for (i = 0; i < 8; i++)
			data[i*32 +: 32] = mem_word({line, 3'(i)});  // word 0 in the low bits.
		return data;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
	                           input logic [31:0] want);
		if (got !== want) begin
			$display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, want);
			errors++;
		end
	endtask

	task automatic load_patterns(output bit ok);
		int          fd;
		int          n;
		int          tn;
		int          sm;
		string       text;
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] e;
		ok = 1'b0;
		fd = $fopen("dv/tlb_walk_patterns.txt", "r");
		if (fd == 0) begin
			$display("could not open dv/tlb_walk_patterns.txt");
		end else begin
			ok = 1'b1;
			while (!$feof(fd)) begin
				n = $fgets(text, fd);
				if (n > 0 && text.getc(0) == "M") begin
					n = $sscanf(text, "M %h %h", a, d);
					mem[a[29:0]] = d;
				end else if (n > 0 && text.getc(0) == "D") begin
					n = $sscanf(text, "D %h", a);
					dead_line[a[26:0]] = 1'b1;
				end else if (n > 0 && text.getc(0) == "R" && num_tests < max_tests) begin
					n = $sscanf(text, "R %d %h %h %h %d", tn, a, d, e, sm);
					t_num[num_tests]     = tn;
					t_ptbr[num_tests]    = a[19:0];
					t_reqaddr[num_tests] = d[19:0];
					t_expect[num_tests]  = e;
					t_stall[num_tests]   = sm;
					num_tests++;
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic wait_response(output bit seen);
		int cycles;
		seen   = 1'b0;
		cycles = 0;
		while (!seen && cycles < resp_limit) begin
			@(posedge clkrst_mem_clk);
			cycles++;
			seen = request && !stall;
		end
	endtask

	// response cycles seen on the TLB side.
	always @(posedge clkrst_mem_clk) begin
		if (clkrst_mem_rst_n && request && !stall)
			resp_seen <= resp_seen + 1;
	end

	// arbiter and memory model.
	always @(posedge clkrst_mem_clk) begin
		if (clkrst_mem_rst_n) begin
			rand_state = lcg_next(rand_state);
			arb_stall  <= stall_en && (rand_state[17:16] == 2'b00);
			arb_rvalid <= 1'b0;
			if (held) begin
				check_value("arb_valid under stall", {31'b0, arb_valid}, 32'h1);
				check_value("arb_addr under stall", {5'b0, arb_addr}, {5'b0, held_addr});
			end
			held      <= arb_valid && arb_stall;
			held_addr <= arb_addr;
			if (arb_valid && !arb_stall) begin
				check_value("arb_opcode", {29'b0, arb_opcode}, {29'b0, ltc_opc_read});
				check_value("arb_wbe", arb_wbe, 32'h0);
				for (int wi = 0; wi < 8; wi++)
					check_value("arb_wdata", arb_wdata[wi*32 +: 32], 32'h0);
				if (read_total - read_base > 1)
					check_value("reads in walk", read_total - read_base + 1, 32'd2);
				else
					check_value("arb_addr", {5'b0, arb_addr},
					            {5'b0, exp_line[read_total - read_base]});
				if (!dead_line.exists(arb_addr)) begin
					if (rand_state[6:4] == 3'd0) begin  // 1 to 8 cycles to rvalid.
						arb_rvalid <= 1'b1;
						arb_rdata  <= build_line(arb_addr);
					end else begin
						busy      <= 1'b1;
						busy_line <= arb_addr;
						latency   <= rand_state[6:4] - 3'd1;
					end
				end
				read_total <= read_total + 1;
			end
			if (busy) begin
				if (latency == 3'd0) begin
					arb_rvalid <= 1'b1;
					arb_rdata  <= build_line(busy_line);
					busy       <= 1'b0;
				end else begin
					latency <= latency - 3'd1;
				end
			end
		end
	end

	initial begin
		int          i;
		int          reads;
		int          want_reads;
		int          test_errors;
		int          failed_tests;
		int          done_tests;
		bit          ok;
		bit          seen;
		logic [29:0] l1_addr;
		logic [29:0] l2_addr;
		logic [31:0] dir_word;

		clkrst_mem_rst_n <= 1'b0;
		request          <= 1'b0;
		reqaddr          <= '0;
		ptbr             <= '0;
		failed_tests = 0;
		done_tests   = 0;
		seen         = 1'b1;
		load_patterns(ok);
		repeat (2) @(posedge clkrst_mem_clk);
		clkrst_mem_rst_n <= 1'b1;
		@(posedge clkrst_mem_clk);
		check_value("stall after reset", {31'b0, stall}, 32'h0);
		check_value("arb_valid after reset", {31'b0, arb_valid}, 32'h0);

		for (i = 0; i < num_tests && ok && seen; i++) begin
			test_errors = errors;
			l1_addr     = {t_ptbr[i], t_reqaddr[i][19:10]};
			dir_word    = mem_word(l1_addr);
			l2_addr     = {dir_word[31:12], t_reqaddr[i][9:0]};
			exp_line[0] = l1_addr[29:3];
			exp_line[1] = l2_addr[29:3];
			// a missing directory or a dead level-1 line ends the walk after one read.
			want_reads  = (dead_line.exists(l1_addr[29:3]) || !dir_word[0]) ? 1 : 2;
			read_base   = read_total;
			request  <= 1'b1;
			ptbr     <= t_ptbr[i];
			reqaddr  <= t_reqaddr[i];
			stall_en <= (t_stall[i] != 0);
			wait_response(seen);
			if (!seen) begin
				$display("test %0d timed out waiting for stall to drop", t_num[i]);
				errors++;
			end else begin
				reads = read_total - read_base;
				check_value("response", response, t_expect[i]);
				check_value("line reads", reads, want_reads);
				done_tests++;
				if (errors != test_errors)
					failed_tests++;
				$display("test %0d: %s, %0d reads, response 0x%08h", t_num[i],
				         (errors == test_errors) ? "ok" : "mismatch", reads, response);
				if (i % 2 == 1) begin
					request <= 1'b0;  // idle gap, the others run back to back.
					@(posedge clkrst_mem_clk);
				end
			end
		end

		request <= 1'b0;
		@(posedge clkrst_mem_clk);
		@(posedge clkrst_mem_clk);
		if (!ok)
			errors++;
		check_value("response cycles", resp_seen, done_tests);
		$display("%0d tests run, %0d failed, %0d errors", done_tests, failed_tests, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- dv/tlb_walk_patterns.txt
# M <word address> <data>   memory image, 30-bit word address
# D <line address>          line the arbiter model never answers
# R <test> <ptbr> <reqaddr> <expected response> <random stall 0/1>
M 00004001 00020007
M 00008003 abcde00b
M 00008007 12345008
M 00004402 00030006
M 00004808 00040005
D 00000900
D 00002002
# present directory and present leaf
R 1 00010 00403 abcde00f 0
# directory not present
R 2 00011 00805 00000000 0
# leaf not present
R 3 00010 00407 1234500c 0
# the same walks under random stall
R 4 00010 00403 abcde00f 1
R 5 00011 00805 00000000 1
R 6 00010 00407 1234500c 1
# level-1 line never answered
R 7 00012 00c00 00000010 0
R 8 00010 00403 abcde00f 1
# level-2 line never answered
R 9 00012 02011 00000010 1
R 10 00010 00407 1234500c 0

//--- files.f
common/tlb_walk_pkg.sv
hw/tlb_walk/walk_fsm.sv
hw/tlb_walk/arb_read_issue.sv
hw/tlb_walk/line_word_select.sv
hw/tlb_walk/walk_timer.sv
hw/tlb_walk/tlb_walk_top.sv
dv/tlb_walk_tb.sv

//--- Makefile
# Verilator build and run of the page-table walker testbench.

VERILATOR ?= verilator
TOP       ?= tlb_walk_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help build test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   list these targets"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: build
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "Test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
